// ==== pet_io_pkg.sv ====
`default_nettype none

package pet_io_pkg;

    // CPU bus
    localparam int DATA_WIDTH = 8;
    localparam int ADDR_WIDTH = 16;

    // Upper address byte of the I/O page ($E8xx)
    localparam logic [ADDR_WIDTH-DATA_WIDTH-1:0] IO_PAGE = 8'hE8;

    // Register select widths
    localparam int PIA_RS_WIDTH = 2;                // PIA uses A1..A0
    localparam int VIA_RS_WIDTH = 4;                // VIA uses A3..A0

    // Shadow index is {device code, 4-bit register select}
    localparam int IO_REG_ADDR_WIDTH = 6;
    localparam int IO_REG_COUNT      = 48;          // Three devices of 16 slots each

    // Device codes, upper bits of the shadow index
    localparam logic [IO_REG_ADDR_WIDTH-VIA_RS_WIDTH-1:0] REG_IO_PIA1 = 2'd0;
    localparam logic [IO_REG_ADDR_WIDTH-VIA_RS_WIDTH-1:0] REG_IO_PIA2 = 2'd1;
    localparam logic [IO_REG_ADDR_WIDTH-VIA_RS_WIDTH-1:0] REG_IO_VIA  = 2'd2;

    // PIA register selects
    localparam logic [PIA_RS_WIDTH-1:0] PIA_PORTA = 2'd0;    // Port A data/direction
    localparam logic [PIA_RS_WIDTH-1:0] PIA_PORTB = 2'd2;    // Port B data/direction

    // Shadow slot of PIA1 port A, PIA select zero-extended to 4 bits
    localparam logic [IO_REG_ADDR_WIDTH-1:0] REG_IO_PIA1_PORTA =
        {REG_IO_PIA1, {(VIA_RS_WIDTH-PIA_RS_WIDTH){1'b0}}, PIA_PORTA};

    // Keyboard column field inside PIA1 port A
    localparam int PIA1_PORTA_KEY_A_OUT = 0;        // LSB of column select
    localparam int PIA1_PORTA_KEY_D_OUT = 3;        // MSB of column select

    // Keyboard matrix geometry
    localparam int KBD_COL_COUNT = 10;
    localparam int KBD_ROW_COUNT = 8;
    localparam int KBD_COL_WIDTH = PIA1_PORTA_KEY_D_OUT - PIA1_PORTA_KEY_A_OUT + 1;

    // Active-low matrix, all ones means nothing pressed
    localparam logic [KBD_ROW_COUNT-1:0] ROW_IDLE = '1;

endpackage

`default_nettype wire

// ==== pet_io_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

// Combinational decode of the $E8xx I/O page into PIA/VIA selects
module pet_io_decode import pet_io_pkg::*; (
    input  wire logic [ADDR_WIDTH-1:0]        cpu_addr_i,
    output logic                              pia1_cs_o,      // A4 only
    output logic                              pia2_cs_o,      // A5 only
    output logic                              via_cs_o,       // A6 only
    output logic [PIA_RS_WIDTH-1:0]           pia_rs_o,       // A1..A0
    output logic [IO_REG_ADDR_WIDTH-1:0]      io_reg_addr_o   // Contiguous shadow index
);

    logic                    io_page;                     // Upper byte hits I/O page
    logic [2:0]              dev_sel;                     // A6..A4
    logic [VIA_RS_WIDTH-1:0] via_rs;                      // A3..A0

    assign io_page = (cpu_addr_i[ADDR_WIDTH-1:DATA_WIDTH] == IO_PAGE);
    assign dev_sel = cpu_addr_i[6:4];
    assign via_rs  = cpu_addr_i[VIA_RS_WIDTH-1:0];
    assign pia_rs_o = cpu_addr_i[PIA_RS_WIDTH-1:0];

    // Exactly one of A4..A6 may be set, otherwise nothing is selected
    assign pia1_cs_o = io_page && (dev_sel == 3'b001);
    assign pia2_cs_o = io_page && (dev_sel == 3'b010);
    assign via_cs_o  = io_page && (dev_sel == 3'b100);

    always_comb begin
        // Device code on top, register select below
        if (pia1_cs_o) begin
            io_reg_addr_o = {REG_IO_PIA1, {(VIA_RS_WIDTH-PIA_RS_WIDTH){1'b0}}, pia_rs_o};
        end else if (pia2_cs_o) begin
            io_reg_addr_o = {REG_IO_PIA2, {(VIA_RS_WIDTH-PIA_RS_WIDTH){1'b0}}, pia_rs_o};
        end else if (via_cs_o) begin
            io_reg_addr_o = {REG_IO_VIA, via_rs};         // VIA uses all four select bits
        end else begin
            io_reg_addr_o = '0;                           // Don't care, no select active
        end
    end

endmodule

`default_nettype wire

// ==== pet_io_shadow.sv ====
`timescale 1ns/1ps
`default_nettype none

// Shadow copy of every byte the CPU writes to PIA1, PIA2 and the VIA
module pet_io_shadow import pet_io_pkg::*; (
    input  wire logic                         wb_clock_i,
    input  wire logic                         rst_n_i,
    input  wire logic                         cpu_wr_strobe_i,  // One-cycle pulse in a write
    input  wire logic [DATA_WIDTH-1:0]        cpu_data_i,
    input  wire logic                         pia1_cs_i,
    input  wire logic                         pia2_cs_i,
    input  wire logic                         via_cs_i,
    input  wire logic [IO_REG_ADDR_WIDTH-1:0] io_reg_addr_i,
    output logic      [KBD_COL_WIDTH-1:0]     porta_col_o,      // Latched keyboard column
    output logic                              io_wr_busy_o      // Strobed I/O write this cycle
);

    logic [IO_REG_COUNT-1:0][DATA_WIDTH-1:0] shadow_regs;
    logic                                    io_access;
    logic                                    io_wr;

    assign io_access = pia1_cs_i || pia2_cs_i || via_cs_i;
    assign io_wr     = io_access && cpu_wr_strobe_i;

    // Scan stage freezes while this is high
    assign io_wr_busy_o = io_wr;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            shadow_regs <= '0;
        end else if (io_wr) begin
            shadow_regs[io_reg_addr_i] <= cpu_data_i;     // Index never exceeds 47
        end
    end

    // Column field of PIA1 port A, visible the cycle after the write edge
    assign porta_col_o =
        shadow_regs[REG_IO_PIA1_PORTA][PIA1_PORTA_KEY_D_OUT:PIA1_PORTA_KEY_A_OUT];

endmodule

`default_nettype wire

// ==== pet_io_kbd_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

// Two-stage column select and USB matrix lookup
module pet_io_kbd_scan import pet_io_pkg::*; (
    input  wire logic                                   wb_clock_i,
    input  wire logic                                   rst_n_i,
    input  wire logic                                   io_wr_busy_i,   // Hold during writes
    input  wire logic [KBD_COL_WIDTH-1:0]               porta_col_i,
    input  wire logic [KBD_COL_COUNT*KBD_ROW_COUNT-1:0] usb_kbd_i,      // Column c at c*8 +: 8
    output logic      [KBD_ROW_COUNT-1:0]               row_data_o
);

    logic [KBD_COL_WIDTH-1:0] selected_col;    // First stage
    logic [KBD_ROW_COUNT-1:0] row_lookup;      // Wide mux output

    // Columns 10..15 do not exist on the PET matrix
    always_comb begin
        if (selected_col < KBD_COL_COUNT) begin
            row_lookup = usb_kbd_i[selected_col*KBD_ROW_COUNT +: KBD_ROW_COUNT];
        end else begin
            row_lookup = ROW_IDLE;
        end
    end

    // Registering the select first keeps the shadow read off the mux path
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            selected_col <= '0;
            row_data_o   <= ROW_IDLE;                  // No key down after reset
        end else if (!io_wr_busy_i) begin
            selected_col <= porta_col_i;
            row_data_o   <= row_lookup;                // Uses previous column select
        end
    end

endmodule

`default_nettype wire

// ==== pet_io_intercept.sv ====
`timescale 1ns/1ps
`default_nettype none

// Replaces PIA1 port B read data with the USB keyboard row
module pet_io_intercept import pet_io_pkg::*; (
    input  wire logic                     wb_clock_i,
    input  wire logic                     rst_n_i,
    input  wire logic                     cpu_be_i,       // Bus cycle enable
    input  wire logic                     cpu_we_i,       // High for write cycles
    input  wire logic                     pia1_cs_i,
    input  wire logic [PIA_RS_WIDTH-1:0]  pia_rs_i,
    input  wire logic [KBD_ROW_COUNT-1:0] row_data_i,     // From scan stage
    output logic      [DATA_WIDTH-1:0]    cpu_data_o,
    output logic                          cpu_data_oe_o   // Drive bus, one cycle
);

    logic cpu_rd;         // Read cycle on the bus
    logic portb_rd;       // Read of PIA1 port B
    logic key_down;       // Selected row has a pressed key

    assign cpu_rd   = cpu_be_i && !cpu_we_i;
    assign portb_rd = cpu_rd && pia1_cs_i && (pia_rs_i == PIA_PORTB);
    assign key_down = (row_data_i != ROW_IDLE);

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cpu_data_o    <= '0;
            cpu_data_oe_o <= 1'b0;
        end else begin
            cpu_data_oe_o <= 1'b0;                    // Default, pulse only

            if (portb_rd) begin
                // Row byte is always loaded
                cpu_data_o    <= row_data_i;
                cpu_data_oe_o <= key_down;            // Real PIA answers when idle
            end
        end
    end

endmodule

`default_nettype wire

// ==== pet_io.sv ====
`timescale 1ns/1ps
`default_nettype none

// PET I/O intercept, decode -> shadow -> scan -> intercept
module pet_io import pet_io_pkg::*; (
    input  wire logic                                   wb_clock_i,
    input  wire logic                                   rst_n_i,
    input  wire logic [ADDR_WIDTH-1:0]                  cpu_addr_i,
    input  wire logic                                   cpu_be_i,
    input  wire logic                                   cpu_we_i,
    input  wire logic                                   cpu_wr_strobe_i,
    input  wire logic [DATA_WIDTH-1:0]                  cpu_data_i,
    input  wire logic [KBD_COL_COUNT*KBD_ROW_COUNT-1:0] usb_kbd_i,       // USB key matrix
    output logic      [DATA_WIDTH-1:0]                  cpu_data_o,
    output logic                                        cpu_data_oe_o
);

    logic                         pia1_cs;
    logic                         pia2_cs;
    logic                         via_cs;
    logic [PIA_RS_WIDTH-1:0]      pia_rs;
    logic [IO_REG_ADDR_WIDTH-1:0] io_reg_addr;
    logic [KBD_COL_WIDTH-1:0]     porta_col;      // Shadowed column field
    logic                         io_wr_busy;
    logic [KBD_ROW_COUNT-1:0]     row_data;       // Row of selected column

    pet_io_decode u_decode (
        .cpu_addr_i    (cpu_addr_i),
        .pia1_cs_o     (pia1_cs),
        .pia2_cs_o     (pia2_cs),
        .via_cs_o      (via_cs),
        .pia_rs_o      (pia_rs),
        .io_reg_addr_o (io_reg_addr)
    );

    pet_io_shadow u_shadow (
        .wb_clock_i      (wb_clock_i),
        .rst_n_i         (rst_n_i),
        .cpu_wr_strobe_i (cpu_wr_strobe_i),
        .cpu_data_i      (cpu_data_i),
        .pia1_cs_i       (pia1_cs),
        .pia2_cs_i       (pia2_cs),
        .via_cs_i        (via_cs),
        .io_reg_addr_i   (io_reg_addr),
        .porta_col_o     (porta_col),
        .io_wr_busy_o    (io_wr_busy)
    );

    pet_io_kbd_scan u_kbd_scan (
        .wb_clock_i   (wb_clock_i),
        .rst_n_i      (rst_n_i),
        .io_wr_busy_i (io_wr_busy),
        .porta_col_i  (porta_col),
        .usb_kbd_i    (usb_kbd_i),
        .row_data_o   (row_data)
    );

    pet_io_intercept u_intercept (
        .wb_clock_i    (wb_clock_i),
        .rst_n_i       (rst_n_i),
        .cpu_be_i      (cpu_be_i),
        .cpu_we_i      (cpu_we_i),
        .pia1_cs_i     (pia1_cs),
        .pia_rs_i      (pia_rs),
        .row_data_i    (row_data),
        .cpu_data_o    (cpu_data_o),
        .cpu_data_oe_o (cpu_data_oe_o)
    );

endmodule

`default_nettype wire

// ==== pet_io_props.sv ====
`timescale 1ns/1ps
`default_nettype none

// Output enable rules of the read intercept
module pet_io_intercept_props import pet_io_pkg::*; (
    input wire logic                    wb_clock_i,
    input wire logic                    rst_n_i,
    input wire logic                    cpu_be_i,
    input wire logic                    cpu_we_i,
    input wire logic                    pia1_cs_i,
    input wire logic [PIA_RS_WIDTH-1:0] pia_rs_i,
    input wire logic                    cpu_data_oe_o
);

    logic portb_rd;       // Same condition as the intercept, rebuilt from the bus

    assign portb_rd = cpu_be_i && !cpu_we_i && pia1_cs_i && (pia_rs_i == PIA_PORTB);

    a_oe_after_read: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        cpu_data_oe_o |-> $past(portb_rd))
        else $error("cpu_data_oe_o high without a PIA1 port B read");

    a_oe_one_cycle: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        cpu_data_oe_o |=> !cpu_data_oe_o)
        else $error("cpu_data_oe_o high for two cycles in a row");

    a_oe_in_reset: assert property (@(posedge wb_clock_i) !rst_n_i |-> !cpu_data_oe_o)
        else $error("cpu_data_oe_o high during reset");

endmodule

bind pet_io_intercept pet_io_intercept_props u_props (
    .wb_clock_i    (wb_clock_i),
    .rst_n_i       (rst_n_i),
    .cpu_be_i      (cpu_be_i),
    .cpu_we_i      (cpu_we_i),
    .pia1_cs_i     (pia1_cs_i),
    .pia_rs_i      (pia_rs_i),
    .cpu_data_oe_o (cpu_data_oe_o)
);

`default_nettype wire

// ==== pet_io_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench, acts as the CPU and as the USB host filling the key matrix
module pet_io_tb import pet_io_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 4;                // Column and matrix settle in three
    localparam int FIXED_ROWS   = 16;
    localparam int ROW_COUNT    = FIXED_ROWS + 16;  // Remaining rows are random
    localparam int WATCHDOG_CYCLES = ROW_COUNT * 20 + RESET_CYCLES;
    localparam int MATRIX_W     = KBD_COL_COUNT * KBD_ROW_COUNT;
    localparam int KEY_IDX_W    = $clog2(MATRIX_W);

    // CPU addresses used by the table
    localparam logic [ADDR_WIDTH-1:0] ADDR_PIA1_PA   = 16'hE810;
    localparam logic [ADDR_WIDTH-1:0] ADDR_PIA1_PB   = 16'hE812;
    localparam logic [ADDR_WIDTH-1:0] ADDR_PIA1_PB_M = 16'hE81A;  // A3 ignored by the PIA
    localparam logic [ADDR_WIDTH-1:0] ADDR_PIA2_R0   = 16'hE820;
    localparam logic [ADDR_WIDTH-1:0] ADDR_PIA2_PB   = 16'hE822;
    localparam logic [ADDR_WIDTH-1:0] ADDR_VIA_R0    = 16'hE840;
    localparam logic [ADDR_WIDTH-1:0] ADDR_OFF_PAGE  = 16'hE712;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TWO_SEL   = 16'hE832;  // A4 and A5 both set

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]    wr_addr;          // Setup write
        logic [DATA_WIDTH-1:0]    wr_data;
        logic                     key_on;           // One key down, else all idle
        logic [KBD_COL_WIDTH-1:0] key_col;
        logic [2:0]               key_row;
        logic [ADDR_WIDTH-1:0]    rd_addr;          // Checked access
        logic                     rd_is_write;
        logic                     exp_oe;
        logic [DATA_WIDTH-1:0]    exp_data;         // Only checked with exp_oe
    } stim_row_t;

    logic                    wb_clock;
    logic                    rst_n;
    logic [ADDR_WIDTH-1:0]   cpu_addr;
    logic                    cpu_be;
    logic                    cpu_we;
    logic                    cpu_wr_strobe;
    logic [DATA_WIDTH-1:0]   cpu_data_in;
    logic [MATRIX_W-1:0]     usb_kbd;
    logic [DATA_WIDTH-1:0]   cpu_data;
    logic                    cpu_data_oe;
    stim_row_t               stim_table [ROW_COUNT];
    integer                  seed;

    pet_io dut0 (
        .wb_clock_i      (wb_clock),
        .rst_n_i         (rst_n),
        .cpu_addr_i      (cpu_addr),
        .cpu_be_i        (cpu_be),
        .cpu_we_i        (cpu_we),
        .cpu_wr_strobe_i (cpu_wr_strobe),
        .cpu_data_i      (cpu_data_in),
        .usb_kbd_i       (usb_kbd),
        .cpu_data_o      (cpu_data),
        .cpu_data_oe_o   (cpu_data_oe)
    );

    initial begin
        wb_clock = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clock = ~wb_clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    // Active low matrix with at most one key pressed
    function automatic logic [MATRIX_W-1:0] key_matrix(input logic on,
            input logic [KBD_COL_WIDTH-1:0] col, input logic [2:0] row);
        logic [MATRIX_W-1:0]  m;
        logic [KEY_IDX_W-1:0] bit_idx;
        m       = '1;
        bit_idx = KEY_IDX_W'(int'(col) * KBD_ROW_COUNT + int'(row));
        if (on) begin
            m[bit_idx] = 1'b0;
        end
        return m;
    endfunction

    // Row byte with one pressed bit cleared
    function automatic logic [DATA_WIDTH-1:0] pressed_row_byte(input logic [2:0] row);
        logic [DATA_WIDTH-1:0] one_hot;
        one_hot      = '0;
        one_hot[row] = 1'b1;
        return ~one_hot;
    endfunction

    task automatic set_row(input int idx, input logic [15:0] wr_addr, input logic [7:0] wr_data,
            input logic key_on, input logic [3:0] key_col, input logic [2:0] key_row,
            input logic [15:0] rd_addr, input logic rd_is_write, input logic exp_oe,
            input logic [7:0] exp_data);
        stim_table[idx] = '{wr_addr, wr_data, key_on, key_col, key_row,
                            rd_addr, rd_is_write, exp_oe, exp_data};
    endtask

    task automatic build_table();
        logic [31:0]              rnd;
        logic [KBD_COL_WIDTH-1:0] col;
        logic [KBD_COL_WIDTH-1:0] key_col;
        logic                     key_on;
        logic                     exp_oe;
        // Hits, misses and foreign accesses
        set_row(0,  ADDR_PIA1_PA, 8'h03, 1'b1, 4'd3, 3'd5, ADDR_PIA1_PB,   1'b0, 1'b1, 8'hDF);
        set_row(1,  ADDR_PIA1_PA, 8'h03, 1'b0, 4'd3, 3'd5, ADDR_PIA1_PB,   1'b0, 1'b0, 8'hFF);
        set_row(2,  ADDR_PIA1_PA, 8'h03, 1'b1, 4'd4, 3'd1, ADDR_PIA1_PB,   1'b0, 1'b0, 8'hFF);
        set_row(3,  ADDR_PIA1_PA, 8'hF7, 1'b1, 4'd7, 3'd0, ADDR_PIA1_PA,   1'b0, 1'b0, 8'hFF);
        set_row(4,  ADDR_PIA1_PA, 8'h07, 1'b1, 4'd7, 3'd0, ADDR_PIA2_PB,   1'b0, 1'b0, 8'hFF);
        set_row(5,  ADDR_PIA1_PA, 8'h07, 1'b1, 4'd7, 3'd0, ADDR_VIA_R0,    1'b0, 1'b0, 8'hFF);
        set_row(6,  ADDR_PIA1_PA, 8'h07, 1'b1, 4'd7, 3'd0, ADDR_OFF_PAGE,  1'b0, 1'b0, 8'hFF);
        set_row(7,  ADDR_PIA1_PA, 8'h07, 1'b1, 4'd7, 3'd0, ADDR_TWO_SEL,   1'b0, 1'b0, 8'hFF);
        set_row(8,  ADDR_PIA1_PA, 8'h07, 1'b1, 4'd7, 3'd0, ADDR_PIA1_PB,   1'b1, 1'b0, 8'hFF);
        set_row(9,  ADDR_PIA1_PA, 8'h07, 1'b1, 4'd7, 3'd0, ADDR_PIA1_PB_M, 1'b0, 1'b1, 8'hFE);
        // Columns past the matrix
        set_row(10, ADDR_PIA1_PA, 8'h0A, 1'b1, 4'd9, 3'd2, ADDR_PIA1_PB,   1'b0, 1'b0, 8'hFF);
        set_row(11, ADDR_PIA1_PA, 8'h0F, 1'b1, 4'd9, 3'd7, ADDR_PIA1_PB,   1'b0, 1'b0, 8'hFF);
        // PIA2 and VIA writes keep column 9
        set_row(12, ADDR_PIA1_PA, 8'h09, 1'b1, 4'd9, 3'd7, ADDR_PIA1_PB,   1'b0, 1'b1, 8'h7F);
        set_row(13, ADDR_PIA2_R0, 8'h02, 1'b1, 4'd9, 3'd3, ADDR_PIA1_PB,   1'b0, 1'b1, 8'hF7);
        set_row(14, ADDR_VIA_R0,  8'h02, 1'b1, 4'd2, 3'd3, ADDR_PIA1_PB,   1'b0, 1'b0, 8'hFF);
        set_row(15, ADDR_PIA1_PA, 8'h02, 1'b1, 4'd2, 3'd3, ADDR_PIA1_PB,   1'b0, 1'b1, 8'hF7);
        for (int i = FIXED_ROWS; i < ROW_COUNT; i++) begin
            rnd     = $random(seed);
            col     = rnd[3:0];
            key_on  = rnd[4] | rnd[5];                          // Mostly a key down
            key_col = KBD_COL_WIDTH'(int'(rnd[15:8]) % KBD_COL_COUNT);
            if (rnd[6] && int'(col) < KBD_COL_COUNT) begin
                key_col = col;                                  // Force a hit
            end
            exp_oe  = key_on && (int'(col) < KBD_COL_COUNT) && (key_col == col);
            set_row(i, ADDR_PIA1_PA, {rnd[23:20], col}, key_on, key_col, rnd[18:16],
                    ADDR_PIA1_PB, 1'b0, exp_oe, pressed_row_byte(rnd[18:16]));
        end
    endtask

    task automatic drive_cycle(input logic [15:0] addr, input logic [7:0] data,
                               input logic is_write);
        cpu_addr      = addr;
        cpu_data_in   = data;
        cpu_be        = 1'b1;
        cpu_we        = is_write;
        cpu_wr_strobe = is_write;                   // Strobe only inside writes
    endtask

    task automatic drive_idle();
        cpu_addr      = '0;
        cpu_data_in   = '0;
        cpu_be        = 1'b0;
        cpu_we        = 1'b0;
        cpu_wr_strobe = 1'b0;
    endtask

    task automatic run_row(input int idx);
        stim_row_t r;
        r = stim_table[idx];
        @(negedge wb_clock);
        usb_kbd = key_matrix(r.key_on, r.key_col, r.key_row);
        drive_cycle(r.wr_addr, r.wr_data, 1'b1);
        @(negedge wb_clock);
        drive_idle();
        repeat (IDLE_CYCLES) @(negedge wb_clock);
        drive_cycle(r.rd_addr, 8'h00, r.rd_is_write);
        @(negedge wb_clock);                        // One cycle after the read edge
        drive_idle();
        check_value(32'(cpu_data_oe), 32'(r.exp_oe), $sformatf("row %0d output enable", idx));
        if (r.exp_oe) begin
            check_value(32'(cpu_data), 32'(r.exp_data), $sformatf("row %0d row data", idx));
        end
        @(negedge wb_clock);
        check_value(32'(cpu_data_oe), 32'd0, $sformatf("row %0d enable pulse width", idx));
    endtask

    initial begin
        seed      = 32'h2399;
        rst_n     = 1'b0;
        usb_kbd   = '1;
        drive_idle();
        build_table();
        repeat (RESET_CYCLES) @(negedge wb_clock);
        rst_n = 1'b1;
        @(negedge wb_clock);
        check_value(32'(cpu_data_oe), 32'd0, "output enable after reset");
        check_value(32'(cpu_data), 32'd0, "read data after reset");
        for (int i = 0; i < ROW_COUNT; i++) begin
            run_row(i);
        end
        $display("Verification passed");
        $finish;
    end

    // Each row needs about nine cycles
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge wb_clock);
        abort_run("Timeout: the test rows did not finish in the expected time");
    end

endmodule

`default_nettype wire

// ==== pet_io.f ====
pet_io_pkg.sv
pet_io_decode.sv
pet_io_shadow.sv
pet_io_kbd_scan.sv
pet_io_intercept.sv
pet_io.sv
pet_io_props.sv
pet_io_tb.sv

// ==== Makefile ====
# Verilator build and run of the PET I/O intercept testbench

VERILATOR ?= verilator
TOP       ?= pet_io_tb
FILELIST  ?= pet_io.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
